//--- Makefile
VERILATOR = verilator
TB_TOP    = tb_fill_path
RTL_TOP   = fill_path_top
FILELIST  = verilog.f
FLAGS     = --timing --assert --timescale 1ns/100ps
LOG       = sim.log
PASS_MSG  = *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TB_TOP) -f $(FILELIST)
	./obj_dir/V$(TB_TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- fill_arbiter.sv
module fill_arbiter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   fifo_afull_i,
	output logic                   fifo_wren_o,
	output fill_pkg::fill_entry_t  fifo_wdata_o,
	fill_req_if.arbiter            wh_req,
	fill_req_if.arbiter            rf_req
);

	fill_pkg::arb_state_e   state;
	fill_pkg::fill_entry_t  entry_q;
	logic                   wh_ready_q;
	logic                   rf_ready_q;
	logic                   last_wh;	// write hit served last
	logic                   pick_wh;
	logic                   pick_rf;

	assign pick_wh = wh_req.valid && (!rf_req.valid || !last_wh);
	assign pick_rf = rf_req.valid && (!wh_req.valid || last_wh);

	assign wh_req.ready = wh_ready_q;
	assign rf_req.ready = rf_ready_q;

	assign fifo_wren_o  = (state == fill_pkg::ARB_REQ) && !fifo_afull_i;
	assign fifo_wdata_o = entry_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= fill_pkg::ARB_IDLE;
			wh_ready_q <= 1'b0;
			rf_ready_q <= 1'b0;
			last_wh    <= 1'b0;
		end else begin
			case (state)
				fill_pkg::ARB_IDLE: begin
					if (!fifo_afull_i && pick_wh) begin
						wh_ready_q <= 1'b1;
						last_wh    <= 1'b1;
						state      <= fill_pkg::ARB_REQ;
					end else if (!fifo_afull_i && pick_rf) begin
						rf_ready_q <= 1'b1;
						last_wh    <= 1'b0;
						state      <= fill_pkg::ARB_REQ;
					end
				end
				fill_pkg::ARB_REQ: begin
					wh_ready_q <= 1'b0;
					rf_ready_q <= 1'b0;
					if (!fifo_afull_i)
						state <= fill_pkg::ARB_IDLE;	// written this cycle
				end
				default: state <= fill_pkg::ARB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == fill_pkg::ARB_IDLE && !fifo_afull_i && (pick_wh || pick_rf))
			entry_q <= pick_wh ? wh_req.entry : rf_req.entry;
	end

	// a served requester drops valid so its entry is written once
	a_wh_drop: assert property (@(posedge clk) disable iff (!rst_n)
		wh_req.ready |=> !wh_req.valid);

	a_rf_drop: assert property (@(posedge clk) disable iff (!rst_n)
		rf_req.ready |=> !rf_req.valid);

endmodule

//--- fill_fifo.sv
module fill_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wren_i,
	input  fill_pkg::fill_entry_t  wdata_i,
	input  logic                   pop_i,
	output logic                   afull_o,
	output logic                   valid_o,
	output fill_pkg::fill_entry_t  rdata_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	fill_pkg::fill_entry_t  mem [FIFO_DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [CNT_W-1:0]       count;
	logic                   pop;

	assign pop     = pop_i && valid_o;
	assign valid_o = (count != '0);
	assign rdata_o = mem[rd_ptr];	// show-ahead head
	assign afull_o = (count >= CNT_W'(FIFO_DEPTH - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wren_i)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wren_i && !pop)
				count <= count + 1'b1;
			else if (!wren_i && pop)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wren_i)
			mem[wr_ptr] <= wdata_i;
	end

	// the arbiter must respect afull
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		wren_i |-> count != CNT_W'(FIFO_DEPTH));

endmodule

//--- fill_path_top.sv
module fill_path_top #(
	parameter int INDEX_BITS = 3,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          req_valid_i,
	input  fill_pkg::req_op_e             req_op_i,
	input  logic [fill_pkg::ADDR_W-1:0]   req_addr_i,
	input  logic [fill_pkg::DATA_W-1:0]   req_data_i,
	output logic                          req_ready_o,
	output logic                          rsp_valid_o,
	output logic                          rsp_hit_o,
	output logic                          mem_req_o,
	output logic [fill_pkg::ADDR_W-1:0]   mem_addr_o,
	input  logic                          mem_rsp_i,
	input  logic [fill_pkg::DATA_W-1:0]   mem_data_i,
	output logic                          fill_valid_o,
	output fill_pkg::fill_src_e           fill_src_o,
	output logic [fill_pkg::ADDR_W-1:0]   fill_addr_o,
	output logic [fill_pkg::DATA_W-1:0]   fill_data_o,
	input  logic                          fill_pop_i
);

	logic                         miss_valid;
	logic [fill_pkg::ADDR_W-1:0]  miss_addr;
	logic                         busy;
	logic                         fifo_wren;
	logic                         fifo_afull;
	fill_pkg::fill_entry_t        fifo_wdata;
	fill_pkg::fill_entry_t        fill_head;

	fill_req_if wh_req ();
	fill_req_if rf_req ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode, execute, result
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	tag_compare #(.INDEX_BITS(INDEX_BITS)) u_tag_compare (
		.clk, .rst_n, .req_valid_i, .req_op_i, .req_addr_i, .req_data_i,
		.busy_i(busy), .req_ready_o, .rsp_valid_o, .rsp_hit_o,
		.miss_valid_o(miss_valid), .miss_addr_o(miss_addr), .wh_req(wh_req.producer)
	);

	rmiss_handler u_rmiss_handler (
		.clk, .rst_n, .miss_valid_i(miss_valid), .miss_addr_i(miss_addr),
		.mem_rsp_i, .mem_data_i, .busy_o(busy), .mem_req_o, .mem_addr_o,
		.rf_req(rf_req.producer)
	);

	fill_arbiter u_fill_arbiter (
		.clk, .rst_n, .fifo_afull_i(fifo_afull), .fifo_wren_o(fifo_wren),
		.fifo_wdata_o(fifo_wdata), .wh_req(wh_req.arbiter), .rf_req(rf_req.arbiter)
	);

	fill_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fill_fifo (
		.clk, .rst_n, .wren_i(fifo_wren), .wdata_i(fifo_wdata), .pop_i(fill_pop_i),
		.afull_o(fifo_afull), .valid_o(fill_valid_o), .rdata_o(fill_head)
	);

	assign fill_src_o  = fill_head.src;	// head entry split for the data array
	assign fill_addr_o = fill_head.addr;
	assign fill_data_o = fill_head.data;

endmodule

//--- fill_pkg.sv
package fill_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int ADDR_W = 16;	// word address
	localparam int DATA_W = 32;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} req_op_e;

	typedef enum logic {
		SRC_WRITE_HIT = 1'b0,
		SRC_REFILL    = 1'b1
	} fill_src_e;

	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_REQ  = 1'b1
	} arb_state_e;

	// one word headed for the data array, 49 bits
	typedef struct packed {
		fill_src_e          src;
		logic [ADDR_W-1:0]  addr;
		logic [DATA_W-1:0]  data;
	} fill_entry_t;

endpackage

//--- fill_req_if.sv
interface fill_req_if;

	logic                  valid;
	logic                  ready;	// one-cycle pulse from the arbiter
	fill_pkg::fill_entry_t entry;

	// valid and entry held until ready is seen
	modport producer (
		output valid,
		output entry,
		input  ready
	);

	modport arbiter (
		input  valid,
		input  entry,
		output ready
	);

endinterface

//--- rmiss_handler.sv
module rmiss_handler (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          miss_valid_i,
	input  logic [fill_pkg::ADDR_W-1:0]   miss_addr_i,
	input  logic                          mem_rsp_i,
	input  logic [fill_pkg::DATA_W-1:0]   mem_data_i,
	output logic                          busy_o,
	output logic                          mem_req_o,
	output logic [fill_pkg::ADDR_W-1:0]   mem_addr_o,
	fill_req_if.producer                  rf_req
);

	typedef enum logic [1:0] {
		RM_IDLE,
		RM_WAIT,	// memory request out
		RM_OFFER	// refill entry offered to the arbiter
	} rm_state_e;

	rm_state_e                    state;
	logic [fill_pkg::ADDR_W-1:0]  miss_addr_q;
	logic [fill_pkg::DATA_W-1:0]  data_q;

	assign busy_o       = (state != RM_IDLE);
	assign mem_addr_o   = miss_addr_q;
	assign rf_req.valid = (state == RM_OFFER);
	assign rf_req.entry = '{src: fill_pkg::SRC_REFILL, addr: miss_addr_q, data: data_q};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= RM_IDLE;
			mem_req_o <= 1'b0;
		end else begin
			mem_req_o <= 1'b0;
			case (state)
				RM_IDLE: begin
					if (miss_valid_i) begin
						mem_req_o <= 1'b1;
						state     <= RM_WAIT;
					end
				end
				RM_WAIT: begin
					if (mem_rsp_i)
						state <= RM_OFFER;
				end
				RM_OFFER: begin
					if (rf_req.ready)
						state <= RM_IDLE;	// entry taken
				end
				default: state <= RM_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RM_IDLE && miss_valid_i)
			miss_addr_q <= miss_addr_i;
		if (state == RM_WAIT && mem_rsp_i)
			data_q <= mem_data_i;
	end

	// the decode stage holds requests while a miss is in flight
	a_one_miss: assert property (@(posedge clk) disable iff (!rst_n)
		miss_valid_i |-> !busy_o);

endmodule

//--- tag_compare.sv
module tag_compare #(
	parameter int INDEX_BITS = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          req_valid_i,
	input  fill_pkg::req_op_e             req_op_i,
	input  logic [fill_pkg::ADDR_W-1:0]   req_addr_i,
	input  logic [fill_pkg::DATA_W-1:0]   req_data_i,
	input  logic                          busy_i,
	output logic                          req_ready_o,
	output logic                          rsp_valid_o,
	output logic                          rsp_hit_o,
	output logic                          miss_valid_o,
	output logic [fill_pkg::ADDR_W-1:0]   miss_addr_o,
	fill_req_if.producer                  wh_req
);

	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_W = fill_pkg::ADDR_W - INDEX_BITS;

	logic [LINES-1:0]             line_valid;
	logic [TAG_W-1:0]             line_tag [LINES];

	logic                         stage_valid;
	fill_pkg::req_op_e            stage_op;
	logic [fill_pkg::ADDR_W-1:0]  stage_addr;
	logic [fill_pkg::DATA_W-1:0]  stage_data;
	logic [INDEX_BITS-1:0]        stage_idx;
	logic [TAG_W-1:0]             stage_tag;

	logic accept, hit, wr_hit;
	logic wh_hold, wh_hold_n;
	logic miss_wait, miss_wait_n;

	assign accept    = req_valid_i && req_ready_o;
	assign stage_idx = stage_addr[INDEX_BITS-1:0];
	assign stage_tag = stage_addr[fill_pkg::ADDR_W-1:INDEX_BITS];
	assign hit       = line_valid[stage_idx] && (line_tag[stage_idx] == stage_tag);
	assign wr_hit    = stage_valid && (stage_op == fill_pkg::OP_WRITE) && hit;

	assign rsp_valid_o  = stage_valid;
	assign rsp_hit_o    = hit;
	assign miss_valid_o = stage_valid && (stage_op == fill_pkg::OP_READ) && !hit;
	assign miss_addr_o  = stage_addr;

	assign wh_req.valid = wr_hit || wh_hold;
	assign wh_req.entry = '{src: fill_pkg::SRC_WRITE_HIT, addr: stage_addr, data: stage_data};

	assign wh_hold_n   = wh_req.valid && !wh_req.ready;
	assign miss_wait_n = miss_valid_o || (miss_wait && busy_i);	// until refill is taken

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_ready_o <= 1'b0;
			stage_valid <= 1'b0;
			wh_hold     <= 1'b0;
			miss_wait   <= 1'b0;
			line_valid  <= '0;
		end else begin
			stage_valid <= accept;
			wh_hold     <= wh_hold_n;
			miss_wait   <= miss_wait_n;
			req_ready_o <= !accept && !wh_hold_n && !miss_wait_n;
			if (miss_valid_o)
				line_valid[stage_idx] <= 1'b1;	// allocate on read miss
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			stage_op   <= req_op_i;
			stage_addr <= req_addr_i;
			stage_data <= req_data_i;
		end
		if (miss_valid_o)
			line_tag[stage_idx] <= stage_tag;
	end

	a_wh_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wh_req.valid && !wh_req.ready |=> wh_req.valid && $stable(wh_req.entry));

endmodule

//--- tb_fill_path.sv
module tb_fill_path;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int INDEX_BITS = 3;
	localparam int FIFO_DEPTH = 4;
	localparam int LINES      = 1 << INDEX_BITS;
	localparam int NUM_REQ    = 400;

	bit                           clk;
	logic                         rst_n;
	logic                         req_valid_i;
	fill_pkg::req_op_e            req_op_i;
	logic [fill_pkg::ADDR_W-1:0]  req_addr_i;
	logic [fill_pkg::DATA_W-1:0]  req_data_i;
	logic                         req_ready_o;
	logic                         rsp_valid_o;
	logic                         rsp_hit_o;
	logic                         mem_req_o;
	logic [fill_pkg::ADDR_W-1:0]  mem_addr_o;
	logic                         mem_rsp_i;
	logic [fill_pkg::DATA_W-1:0]  mem_data_i;
	logic                         fill_valid_o;
	fill_pkg::fill_src_e          fill_src_o;
	logic [fill_pkg::ADDR_W-1:0]  fill_addr_o;
	logic [fill_pkg::DATA_W-1:0]  fill_data_o;
	logic                         fill_pop_i;

	integer seed = 7;

	// reference model
	bit                           tag_valid [LINES];
	logic [fill_pkg::ADDR_W-1:0]  tag_addr [LINES];
	fill_pkg::fill_entry_t        wh_q [$];	// expected write-hit entries
	fill_pkg::fill_entry_t        rf_q [$];	// expected refill entries
	logic [fill_pkg::ADDR_W-1:0]  mem_q [$];	// expected memory requests
	bit                           rsp_due;
	bit                           exp_hit;

	fill_path_top #(.INDEX_BITS(INDEX_BITS), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
		.clk, .rst_n, .req_valid_i, .req_op_i, .req_addr_i, .req_data_i,
		.req_ready_o, .rsp_valid_o, .rsp_hit_o, .mem_req_o, .mem_addr_o,
		.mem_rsp_i, .mem_data_i, .fill_valid_o, .fill_src_o, .fill_addr_o,
		.fill_data_o, .fill_pop_i
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic fail_now(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_hit(input string name, input bit exp, input bit act);
		if (exp !== act)
			fail_now($sformatf("Mismatch in %s: expected %0b, actual %0b", name, exp, act));
	endtask

	task automatic check_fill(input string name, input fill_pkg::fill_entry_t exp,
			input fill_pkg::fill_entry_t act);
		if (exp !== act)
			fail_now($sformatf("Mismatch in %s: expected %0d/%h/%h, actual %0d/%h/%h",
				name, exp.src, exp.addr, exp.data, act.src, act.addr, act.data));
	endtask

	task automatic check_mem_addr(input string name, input logic [fill_pkg::ADDR_W-1:0] exp,
			input logic [fill_pkg::ADDR_W-1:0] act);
		if (exp !== act)
			fail_now($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
	endtask

	// one request, held until the DUT takes it
	task automatic send_request();
		logic [31:0] r;
		int gap;
		r = $random(seed);
		req_valid_i = 1'b1;
		req_op_i    = r[0] ? fill_pkg::OP_WRITE : fill_pkg::OP_READ;
		req_addr_i  = fill_pkg::ADDR_W'(r[7:4]);	// 16 words over 8 lines
		req_data_i  = $random(seed);
		gap         = int'(r[10:9]);
		@(negedge clk);
		while (!req_ready_o)
			@(negedge clk);
		@(posedge clk);
		#1;
		req_valid_i = 1'b0;
		#(gap * CLK_PERIOD);
	endtask

	// everything is sampled at the falling edge, half a cycle clear of the drive
	always @(negedge clk) begin : monitor
		fill_pkg::fill_entry_t e;
		int idx;
		if (!rst_n) begin
			check_hit("ready_in_reset", 1'b0, req_ready_o);
			check_hit("rsp_valid_in_reset", 1'b0, rsp_valid_o);
			check_hit("fill_valid_in_reset", 1'b0, fill_valid_o);
			rsp_due = 1'b0;
		end else begin
			check_hit("rsp_valid", rsp_due, rsp_valid_o);
			if (rsp_due)
				check_hit("rsp_hit", exp_hit, rsp_hit_o);
			rsp_due = req_valid_i && req_ready_o;
			if (rsp_due) begin
				idx     = int'(req_addr_i[INDEX_BITS-1:0]);
				exp_hit = tag_valid[idx] && (tag_addr[idx] == req_addr_i);
				if (req_op_i == fill_pkg::OP_WRITE && exp_hit) begin
					e.src  = fill_pkg::SRC_WRITE_HIT;
					e.addr = req_addr_i;
					e.data = req_data_i;
					wh_q.push_back(e);
				end else if (req_op_i == fill_pkg::OP_READ && !exp_hit) begin
					tag_valid[idx] = 1'b1;	// allocate
					tag_addr[idx]  = req_addr_i;
					mem_q.push_back(req_addr_i);
				end
			end
			if (fill_valid_o && fill_pop_i) begin
				e.src  = fill_src_o;
				e.addr = fill_addr_o;
				e.data = fill_data_o;
				if (e.src == fill_pkg::SRC_WRITE_HIT) begin
					if (wh_q.size() == 0)
						fail_now("a write-hit entry left the FIFO when none was expected");
					check_fill("write_hit_entry", wh_q.pop_front(), e);
				end else begin
					if (rf_q.size() == 0)
						fail_now("a refill entry left the FIFO when none was expected");
					check_fill("refill_entry", rf_q.pop_front(), e);
				end
			end
			// FIFO plus arbiter slot plus one per requester
			if (wh_q.size() + rf_q.size() > FIFO_DEPTH + 2)
				fail_now("more fill entries pending than the fill path can hold");
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory and data array side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin : mem_responder
		fill_pkg::fill_entry_t e;
		logic [fill_pkg::ADDR_W-1:0] exp_addr;
		int delay;
		mem_rsp_i  = 1'b0;
		mem_data_i = '0;
		forever begin
			@(negedge clk);
			if (rst_n && mem_req_o) begin
				if (mem_q.size() == 0)
					fail_now("memory request issued with no read miss outstanding");
				exp_addr = mem_q.pop_front();
				check_mem_addr("mem_addr", exp_addr, mem_addr_o);
				delay = 1 + int'($unsigned($random(seed)) % 8);
				repeat (delay) @(posedge clk);
				#1;
				mem_data_i = $random(seed);
				mem_rsp_i  = 1'b1;
				e.src  = fill_pkg::SRC_REFILL;
				e.addr = exp_addr;
				e.data = mem_data_i;
				rf_q.push_back(e);
				@(posedge clk);
				#1;
				mem_rsp_i = 1'b0;
			end
		end
	end

	initial begin : pop_driver
		logic [31:0] r;
		int hold;
		hold       = 0;
		fill_pop_i = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			r = $random(seed);
			if (hold > 0) begin
				fill_pop_i = 1'b0;
				hold--;
			end else if (r[5:0] == 6'd0) begin
				fill_pop_i = 1'b0;	// long stall, 31 cycles or more
				hold       = 30 + int'(r[9:6]);
			end else
				fill_pop_i = (r[7:6] != 2'b00);
		end
	end

	initial begin : watchdog
		#(NUM_REQ * 40 * CLK_PERIOD);
		fail_now("watchdog expired before all requests were processed");
	end

	initial begin : main
		int n;
		rst_n       = 1'b0;
		req_valid_i = 1'b0;
		req_op_i    = fill_pkg::OP_READ;
		req_addr_i  = '0;
		req_data_i  = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		@(negedge clk);
		check_hit("ready_after_reset", 1'b1, req_ready_o);
		@(posedge clk);
		#1;
		for (int i = 0; i < NUM_REQ; i++)
			send_request();
		n = 0;
		while ((wh_q.size() + rf_q.size() + mem_q.size() != 0 || rsp_due) && n < 200) begin
			@(negedge clk);
			n++;
		end
		repeat (4) @(negedge clk);
		if (wh_q.size() == 0 && rf_q.size() == 0 && mem_q.size() == 0 && !fill_valid_o) begin
			$display("*** PASSED ***");
			$finish;
		end else
			fail_now("fill entries still pending after the drain");
	end

endmodule

//--- verilog.f
fill_pkg.sv
fill_req_if.sv
tag_compare.sv
rmiss_handler.sv
fill_arbiter.sv
fill_fifo.sv
fill_path_top.sv
tb_fill_path.sv
